// File: rtl/bpu_pkg.sv
// ---------------------------------------------------------
// Shared definitions of the branch prediction unit
// Address layout, 2-bit counter states and the default
// sizes of the history register and the BTB
// ---------------------------------------------------------

package bpu_pkg;

  // ---------------------------------------------------------
  // Address layout
  // ---------------------------------------------------------

  // Width of a program counter
  localparam int unsigned XLEN = 32;

  // Low PC bits that never take part in indexing
  // Instructions are 4 bytes, so the two lowest bits are zero
  localparam int unsigned OFFSET = 2;

  // ---------------------------------------------------------
  // Direction counters
  // ---------------------------------------------------------

  // 2-bit saturating counter, MSB is the taken prediction
  typedef enum logic [1:0] {
    SNT = 2'b00,  // strongly not taken
    WNT = 2'b01,  // weakly not taken
    WT  = 2'b10,  // weakly taken
    ST  = 2'b11   // strongly taken
  } c2b_t;

  // ---------------------------------------------------------
  // Default sizes
  // ---------------------------------------------------------

  // Global history length, also the PHT index width
  localparam int unsigned HLEN_DEF = 4;

  // BTB index width, 16 entries
  localparam int unsigned BTB_BITS_DEF = 4;

  // Counter value after reset and flush
  localparam c2b_t INIT_C2B_DEF = WNT;

endpackage

// File: rtl/bpu_resolution_if.sv
// ---------------------------------------------------------
// Branch resolution bundle from execute to the BPU tables
// Source side at the top level, sink side in gshare and BTB
// ---------------------------------------------------------

interface bpu_resolution_if;

  // One-cycle strobe, one per resolved branch
  logic                     valid;
  // PC of the resolved branch
  logic [bpu_pkg::XLEN-1:0] pc;
  // Target computed in execute
  logic [bpu_pkg::XLEN-1:0] target;
  // Actual direction
  logic                     taken;

  // Driving side, no back-pressure
  modport source (
    output valid,
    output pc,
    output target,
    output taken
  );

  // Consuming side, strobe is taken in the cycle it shows up
  modport sink (
    input valid,
    input pc,
    input target,
    input taken
  );

endinterface

// File: rtl/gshare.sv
// ---------------------------------------------------------
// gshare direction predictor
// Global history register, PHT of 2-bit counters and
// history XOR PC indexing for read and update
// ---------------------------------------------------------

module gshare #(
  parameter int unsigned   HLEN     = bpu_pkg::HLEN_DEF,
  parameter bpu_pkg::c2b_t INIT_C2B = bpu_pkg::INIT_C2B_DEF
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic [bpu_pkg::XLEN-1:0] curr_pc_i,
  bpu_resolution_if.sink           res,
  output logic                     taken_o
);

  // One counter per history pattern
  localparam int unsigned PHT_ROWS = 1 << HLEN;
  // PC slice used for hashing, right above the offset
  localparam int unsigned PC_LO    = bpu_pkg::OFFSET;
  localparam int unsigned PC_HI    = bpu_pkg::OFFSET + HLEN - 1;

  // Shift register below needs at least two history bits
  if (HLEN < 2) begin : g_hlen_check
    $error("gshare: HLEN must be at least 2");
  end

  // ---------------------------------------------------------
  // Internal state and indices
  // ---------------------------------------------------------

  // Global history, newest outcome in bit 0
  logic [HLEN-1:0] history_q;
  // Counter table
  bpu_pkg::c2b_t   pht_q [PHT_ROWS];

  // Index for the fetch-side lookup
  logic [HLEN-1:0] rd_idx;
  // Index of the counter trained by a resolution
  logic [HLEN-1:0] wr_idx;
  // Counter under update and its next value
  bpu_pkg::c2b_t   wr_cnt;
  bpu_pkg::c2b_t   wr_cnt_nxt;

  // Both indices hash with the same history value
  assign rd_idx = history_q ^ curr_pc_i[PC_HI:PC_LO];
  assign wr_idx = history_q ^ res.pc[PC_HI:PC_LO];
  assign wr_cnt = pht_q[wr_idx];

  // Prediction is the MSB of the selected counter
  assign taken_o = pht_q[rd_idx][1];

  // ---------------------------------------------------------
  // Global history register
  // ---------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      history_q <= '0;
    end else if (flush_i) begin
      // Flush has priority over a coinciding resolution
      history_q <= '0;
    end else if (res.valid) begin
      history_q <= {history_q[HLEN-2:0], res.taken};
    end
  end

  // ---------------------------------------------------------
  // Pattern history table
  // ---------------------------------------------------------

  // One step toward the outcome, saturating at SNT and ST
  always_comb begin
    case (wr_cnt)
      bpu_pkg::SNT: wr_cnt_nxt = res.taken ? bpu_pkg::WNT : bpu_pkg::SNT;
      bpu_pkg::WNT: wr_cnt_nxt = res.taken ? bpu_pkg::WT  : bpu_pkg::SNT;
      bpu_pkg::WT:  wr_cnt_nxt = res.taken ? bpu_pkg::ST  : bpu_pkg::WNT;
      bpu_pkg::ST:  wr_cnt_nxt = res.taken ? bpu_pkg::ST  : bpu_pkg::WT;
      // Unknown state recovers to the flush value
      default:      wr_cnt_nxt = INIT_C2B;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= INIT_C2B;
      end
    end else if (flush_i) begin
      for (int unsigned i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= INIT_C2B;
      end
    end else if (res.valid) begin
      // Only the hashed entry moves
      pht_q[wr_idx] <= wr_cnt_nxt;
    end
  end

  // ---------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------

  // Fetch PC and table state must give a defined direction
  a_taken_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(taken_o)
  ) else $error("gshare: direction prediction is unknown");

endmodule

// File: rtl/btb.sv
// ---------------------------------------------------------
// Direct-mapped branch target buffer
// Valid bits, tags and targets of taken branches, lookup
// by fetch PC, update and invalidate by resolutions
// ---------------------------------------------------------

module btb #(
  parameter int unsigned BTB_BITS = bpu_pkg::BTB_BITS_DEF
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic [bpu_pkg::XLEN-1:0] curr_pc_i,
  bpu_resolution_if.sink           res,
  output logic                     hit_o,
  output logic [bpu_pkg::XLEN-1:0] target_o
);

  // Table geometry
  localparam int unsigned ROWS   = 1 << BTB_BITS;
  localparam int unsigned IDX_LO = bpu_pkg::OFFSET;
  localparam int unsigned TAG_LO = bpu_pkg::OFFSET + BTB_BITS;
  // Everything above the index is tag
  localparam int unsigned TAG_W  = bpu_pkg::XLEN - TAG_LO;

  // A tag of at least one bit is needed
  if (TAG_LO >= bpu_pkg::XLEN) begin : g_tag_check
    $error("btb: BTB_BITS leaves no tag bits");
  end

  // ---------------------------------------------------------
  // Storage
  // ---------------------------------------------------------

  // Entry valid flags, cleared by reset and flush
  logic [ROWS-1:0]          valid_q;
  // Tag and target payload, only meaningful when valid
  logic [TAG_W-1:0]         tag_q    [ROWS];
  logic [bpu_pkg::XLEN-1:0] target_q [ROWS];

  // ---------------------------------------------------------
  // Index and tag slicing
  // ---------------------------------------------------------

  // Lookup side
  logic [BTB_BITS-1:0] rd_idx;
  logic [TAG_W-1:0]    rd_tag;
  // Update side
  logic [BTB_BITS-1:0] wr_idx;
  logic [TAG_W-1:0]    wr_tag;
  // Resolved branch already owns its entry
  logic                wr_match;

  assign rd_idx = curr_pc_i[TAG_LO-1:IDX_LO];
  assign rd_tag = curr_pc_i[bpu_pkg::XLEN-1:TAG_LO];
  assign wr_idx = res.pc[TAG_LO-1:IDX_LO];
  assign wr_tag = res.pc[bpu_pkg::XLEN-1:TAG_LO];

  // Valid gates the compare, so unwritten tags never match
  assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  // ---------------------------------------------------------
  // Lookup
  // ---------------------------------------------------------

  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  // Target is passed raw, the top level qualifies it
  assign target_o = target_q[rd_idx];

  // ---------------------------------------------------------
  // Update
  // ---------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      // Flush wins over a resolution in the same cycle
      valid_q <= '0;
    end else if (res.valid) begin
      if (res.taken) begin
        // Taken branch allocates, replacing any other tag
        valid_q[wr_idx] <= 1'b1;
      end else if (wr_match) begin
        // Not taken drops only its own entry
        valid_q[wr_idx] <= 1'b0;
      end
    end
  end

  // Payload written together with the valid bit
  always_ff @(posedge clk_i) begin
    if (res.valid && res.taken && !flush_i) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= res.target;
    end
  end

  // ---------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------

  // A hit must point at an entry that was written earlier
  a_hit_target_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    hit_o |-> !$isunknown(target_o)
  ) else $error("btb: hit with unknown target");

endmodule

// File: rtl/bpu_top.sv
// ---------------------------------------------------------
// Branch prediction unit top level
// Joins gshare direction and BTB target into the next
// fetch PC, fans resolutions out to both tables
// ---------------------------------------------------------

module bpu_top #(
  parameter int unsigned   HLEN     = bpu_pkg::HLEN_DEF,
  parameter int unsigned   BTB_BITS = bpu_pkg::BTB_BITS_DEF,
  parameter bpu_pkg::c2b_t INIT_C2B = bpu_pkg::INIT_C2B_DEF
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  // Fetch side
  input  logic [bpu_pkg::XLEN-1:0] curr_pc_i,
  // Resolution from execute
  input  logic                     res_valid_i,
  input  logic [bpu_pkg::XLEN-1:0] res_pc_i,
  input  logic [bpu_pkg::XLEN-1:0] res_target_i,
  input  logic                     res_taken_i,
  // Prediction, combinational from curr_pc_i
  output logic                     pred_taken_o,
  output logic [bpu_pkg::XLEN-1:0] pred_target_o
);

  // Sequential fetch step, one instruction
  localparam logic [bpu_pkg::XLEN-1:0] PC_STEP = 1 << bpu_pkg::OFFSET;

  // ---------------------------------------------------------
  // Resolution fan-out
  // ---------------------------------------------------------

  bpu_resolution_if res_if ();

  // Source side of the bundle, fed from the plain ports
  assign res_if.valid  = res_valid_i;
  assign res_if.pc     = res_pc_i;
  assign res_if.target = res_target_i;
  assign res_if.taken  = res_taken_i;

  // ---------------------------------------------------------
  // Predictor tables
  // ---------------------------------------------------------

  // Direction from gshare
  logic                     dir_taken;
  // Target lookup from the BTB
  logic                     btb_hit;
  logic [bpu_pkg::XLEN-1:0] btb_target;

  gshare #(
    .HLEN     (HLEN),
    .INIT_C2B (INIT_C2B)
  ) i_gshare (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .curr_pc_i (curr_pc_i),
    .res       (res_if.sink),
    .taken_o   (dir_taken)
  );

  btb #(
    .BTB_BITS (BTB_BITS)
  ) i_btb (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .curr_pc_i (curr_pc_i),
    .res       (res_if.sink),
    .hit_o     (btb_hit),
    .target_o  (btb_target)
  );

  // ---------------------------------------------------------
  // Next PC selection
  // ---------------------------------------------------------

  // Taken only when a target is known for this PC
  assign pred_taken_o  = dir_taken & btb_hit;
  // Fall through to the next sequential instruction otherwise
  assign pred_target_o = pred_taken_o ? btb_target : curr_pc_i + PC_STEP;

  // ---------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------

  // Flush empties the BTB, so the next cycle falls through
  a_flush_falls_through : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !pred_taken_o && (pred_target_o == curr_pc_i + PC_STEP)
  ) else $error("bpu_top: taken prediction right after flush");

endmodule

// File: dv/bpu_checker.sv
// ---------------------------------------------------------
// Reference model of the branch prediction unit
// Global history, counter table and BTB arrays, plus
// concurrent assertions on the predicted direction and PC
// ---------------------------------------------------------

module bpu_checker #(
  parameter int unsigned   HLEN     = bpu_pkg::HLEN_DEF,
  parameter int unsigned   BTB_BITS = bpu_pkg::BTB_BITS_DEF,
  parameter bpu_pkg::c2b_t INIT_C2B = bpu_pkg::INIT_C2B_DEF
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic [bpu_pkg::XLEN-1:0] curr_pc_i,
  input  logic                     res_valid_i,
  input  logic [bpu_pkg::XLEN-1:0] res_pc_i,
  input  logic [bpu_pkg::XLEN-1:0] res_target_i,
  input  logic                     res_taken_i,
  input  logic                     pred_taken_i,
  input  logic [bpu_pkg::XLEN-1:0] pred_target_i,
  output int                       err_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned PHT_SIZE  = 2 ** HLEN;
  localparam int unsigned BTB_SIZE  = 2 ** BTB_BITS;
  // PC bits at and above this position form the BTB tag
  localparam int unsigned TAG_SHIFT = bpu_pkg::OFFSET + BTB_BITS;

  // ---------------------------------------------------------
  // Model state
  // ---------------------------------------------------------

  int unsigned              hist;
  // Counters held as plain numbers 0..3, 2 and up means taken
  int unsigned              ctr     [PHT_SIZE];
  bit                       btb_v   [BTB_SIZE];
  // Full branch PC is kept, the tag is cut from it on compare
  logic [bpu_pkg::XLEN-1:0] btb_pc  [BTB_SIZE];
  logic [bpu_pkg::XLEN-1:0] btb_tgt [BTB_SIZE];
  int                       errors = 0;

  assign err_cnt_o = errors;

  task automatic clear_state();
    hist = 0;
    for (int i = 0; i < PHT_SIZE; i++) begin
      ctr[i] = int'(INIT_C2B);
    end
    for (int i = 0; i < BTB_SIZE; i++) begin
      btb_v[i] = 1'b0;
    end
  endtask

  task automatic apply_resolution();
    int unsigned pc_word;
    int unsigned wr_pht;
    int unsigned wr_btb;
    pc_word = res_pc_i >> bpu_pkg::OFFSET;
    wr_pht  = (hist ^ pc_word) % PHT_SIZE;
    wr_btb  = pc_word % BTB_SIZE;
    // Saturating step toward the outcome
    if (res_taken_i && ctr[wr_pht] < 3) begin
      ctr[wr_pht]++;
    end else if (!res_taken_i && ctr[wr_pht] > 0) begin
      ctr[wr_pht]--;
    end
    hist = ((hist << 1) | res_taken_i) % PHT_SIZE;
    if (res_taken_i) begin
      btb_v[wr_btb]   = 1'b1;
      btb_pc[wr_btb]  = res_pc_i;
      btb_tgt[wr_btb] = res_target_i;
    end else if (btb_v[wr_btb] && (btb_pc[wr_btb] >> TAG_SHIFT) == (res_pc_i >> TAG_SHIFT)) begin
      btb_v[wr_btb] = 1'b0;
    end
  endtask

  // Flush beats a resolution in the same cycle
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i || flush_i) begin
      clear_state();
    end else if (res_valid_i) begin
      apply_resolution();
    end
  end

  // ---------------------------------------------------------
  // Expected prediction for the current fetch PC
  // ---------------------------------------------------------

  int unsigned              rd_word;
  int unsigned              rd_pht;
  int unsigned              rd_btb;
  logic                     exp_taken;
  logic [bpu_pkg::XLEN-1:0] exp_target;

  always_comb begin
    rd_word    = curr_pc_i >> bpu_pkg::OFFSET;
    rd_pht     = (hist ^ rd_word) % PHT_SIZE;
    rd_btb     = rd_word % BTB_SIZE;
    exp_taken  = (ctr[rd_pht] >= 2) && btb_v[rd_btb]
                 && ((btb_pc[rd_btb] >> TAG_SHIFT) == (curr_pc_i >> TAG_SHIFT));
    exp_target = exp_taken ? btb_tgt[rd_btb] : curr_pc_i + 32'd4;
  end

  a_pred_taken : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pred_taken_i === exp_taken
  ) else begin
    errors++;
    $display("** Error [%0t] PC %h: pred_taken_o %b, model %b", $time,
             $sampled(curr_pc_i), $sampled(pred_taken_i), $sampled(exp_taken));
  end

  a_pred_target : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pred_target_i === exp_target
  ) else begin
    errors++;
    $display("** Error [%0t] PC %h: pred_target_o %h, model %h", $time,
             $sampled(curr_pc_i), $sampled(pred_target_i), $sampled(exp_target));
  end

endmodule

// File: dv/tb_bpu_top.sv
// ---------------------------------------------------------
// Testbench of the branch prediction unit
// Clock, reset, directed and random stimulus, watchdog
// and the final error report
// ---------------------------------------------------------

module tb_bpu_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned XLEN            = bpu_pkg::XLEN;
  localparam int unsigned CLK_PERIOD      = 8;
  localparam int unsigned RESET_CYCLES    = 8;
  // Upper bound for the directed part
  localparam int unsigned DIRECTED_CYCLES = 120;
  localparam int unsigned RANDOM_CYCLES   = 500;
  localparam int unsigned RUN_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
  localparam int unsigned WATCHDOG_MARGIN = 400;
  localparam int unsigned RAND_SEED       = 32'h5b9e4677;

  // Trained branch and an alias on the same BTB row, other tag
  localparam logic [XLEN-1:0] PC_A  = 32'h0000_1040;
  localparam logic [XLEN-1:0] PC_B  = 32'h0000_1080;
  localparam logic [XLEN-1:0] TGT_A = 32'h0000_2200;
  // Branch on the next BTB row, only steers the history
  localparam logic [XLEN-1:0] PC_C  = 32'h0000_1044;

  logic            clk_i;
  logic            rst_n_i;
  logic            flush_i;
  logic [XLEN-1:0] curr_pc_i;
  logic            res_valid_i;
  logic [XLEN-1:0] res_pc_i;
  logic [XLEN-1:0] res_target_i;
  logic            res_taken_i;
  logic            pred_taken_o;
  logic [XLEN-1:0] pred_target_o;
  int              checker_errors;
  int              directed_errors = 0;
  // Small PC pool, several share BTB rows or PHT rows
  logic [XLEN-1:0] pc_pool [8];

  bpu_top i_dut (
    .clk_i, .rst_n_i, .flush_i, .curr_pc_i,
    .res_valid_i, .res_pc_i, .res_target_i, .res_taken_i,
    .pred_taken_o, .pred_target_o
  );

  bpu_checker i_checker (
    .clk_i, .rst_n_i, .flush_i, .curr_pc_i,
    .res_valid_i, .res_pc_i, .res_target_i, .res_taken_i,
    .pred_taken_i  (pred_taken_o),
    .pred_target_i (pred_target_o),
    .err_cnt_o     (checker_errors)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ---------------------------------------------------------
  // Stimulus tasks, all inputs change on falling edges
  // ---------------------------------------------------------

  task automatic resolve(input logic [XLEN-1:0] pc, input logic taken,
                         input logic [XLEN-1:0] target, input logic flush);
    @(negedge clk_i);
    flush_i      = flush;
    res_valid_i  = 1'b1;
    res_pc_i     = pc;
    res_taken_i  = taken;
    res_target_i = target;
  endtask

  task automatic expect_pred(input logic [XLEN-1:0] pc, input logic taken,
                             input logic [XLEN-1:0] target);
    @(negedge clk_i);
    flush_i     = 1'b0;
    res_valid_i = 1'b0;
    curr_pc_i   = pc;
    #1;
    a_directed : assert (pred_taken_o === taken && pred_target_o === target) else begin
      directed_errors++;
      $display("** Error [%0t] PC %h: got taken %b target %h, expected %b %h",
               $time, pc, pred_taken_o, pred_target_o, taken, target);
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    pc_pool = '{32'h0000_1040, 32'h0000_1080, 32'h0000_1044, 32'h0000_2044,
                32'h0000_1048, 32'h0000_307c, 32'h8000_0040, 32'h0000_1050};
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    flush_i      = 1'b0;
    curr_pc_i    = '0;
    res_valid_i  = 1'b0;
    res_pc_i     = '0;
    res_target_i = '0;
    res_taken_i  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Fresh tables fall through everywhere
    foreach (pc_pool[i]) expect_pred(pc_pool[i], 1'b0, pc_pool[i] + 32'd4);

    // History fills with ones, counter 15 saturates, BTB row 0 holds A
    repeat (6) resolve(PC_A, 1'b1, TGT_A, 1'b0);
    expect_pred(PC_A, 1'b1, TGT_A);

    // Same PHT counter taken, but B misses on the tag
    expect_pred(PC_B, 1'b0, PC_B + 32'd4);
    resolve(PC_A, 1'b0, '0, 1'b0);
    // History back to all ones, counter 15 taken again, row 0 stays empty
    repeat (4) resolve(PC_C, 1'b1, TGT_A, 1'b0);
    expect_pred(PC_A, 1'b0, PC_A + 32'd4);

    // Retrain, then flush with a resolution in the same cycle
    repeat (6) resolve(PC_A, 1'b1, TGT_A, 1'b0);
    expect_pred(PC_A, 1'b1, TGT_A);
    resolve(PC_A, 1'b1, TGT_A, 1'b1);
    foreach (pc_pool[i]) expect_pred(pc_pool[i], 1'b0, pc_pool[i] + 32'd4);

    // ---------------------------------------------------------
    // Random phase, checked by the reference model
    // ---------------------------------------------------------
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      @(negedge clk_i);
      curr_pc_i    = pc_pool[$urandom_range(7, 0)];
      res_valid_i  = $urandom_range(1, 0);
      res_pc_i     = pc_pool[$urandom_range(7, 0)];
      res_taken_i  = $urandom_range(1, 0);
      res_target_i = $urandom() & ~32'h3;
      flush_i      = ($urandom_range(31, 0) == 0);
    end
    @(negedge clk_i);
    res_valid_i = 1'b0;
    flush_i     = 1'b0;
    repeat (2) @(negedge clk_i);

    $display("Errors: %0d model mismatches, %0d directed", checker_errors, directed_errors);
    if (checker_errors == 0 && directed_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the cycle budget of all phases
  initial begin
    #(RUN_CYCLES * CLK_PERIOD + WATCHDOG_MARGIN);
    $display("Timeout: stimulus did not finish within %0d ns",
             RUN_CYCLES * CLK_PERIOD + WATCHDOG_MARGIN);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog.f
rtl/bpu_pkg.sv
rtl/bpu_resolution_if.sv
rtl/gshare.sv
rtl/btb.sv
rtl/bpu_top.sv
dv/bpu_checker.sv
dv/tb_bpu_top.sv

// File: Bender.yml
package:
  name: bpu

sources:
  # Design sources in compile order
  - files:
      - rtl/bpu_pkg.sv
      - rtl/bpu_resolution_if.sv
      - rtl/gshare.sv
      - rtl/btb.sv
      - rtl/bpu_top.sv

  # Testbench sources
  - target: test
    files:
      - dv/bpu_checker.sv
      - dv/tb_bpu_top.sv
